// File: common/cnu_pkg.sv
package cnu_pkg;

	// decoder sizes
	localparam int NUM_CNU     = 4;           // check node lanes
	localparam int DC          = 4;           // check node degree
	localparam int MSG_W       = 4;           // sign + 3 bit magnitude
	localparam int MAG_W       = MSG_W - 1;
	localparam int ITER_NUM    = 3;           // iterations per frame
	localparam int OFFSET      = 1;           // offset min-sum correction

	// credit pools
	localparam int IN_CREDITS  = NUM_CNU;     // upstream credits after reset
	localparam int OUT_CREDITS = 2;           // collector credits after reset

	// derived widths
	localparam int LANE_W      = $clog2(NUM_CNU);
	localparam int IDX_W       = $clog2(DC);
	localparam int ITER_W      = $clog2(ITER_NUM);
	localparam int CRED_W      = $clog2(OUT_CREDITS + 1);

	// sequencer phases
	typedef enum logic [1:0] {
		PHASE_IDLE,
		PHASE_INIT_LOAD,
		PHASE_PIPE_LOAD,
		PHASE_WAIT_WR
	} cnu_phase_e;

	// one sign-magnitude message
	typedef struct packed {
		logic             sign;
		logic [MAG_W-1:0] mag;
	} cnu_msg_t;

	// all DC edges of one check node
	typedef struct packed {
		cnu_msg_t [DC-1:0] msg;
	} cnu_row_t;

	// output beat, row tagged with its lane
	typedef struct packed {
		cnu_row_t          row;
		logic [LANE_W-1:0] lane;
	} cnu_out_t;

endpackage

// File: logic/cnu_wr_update_handshake.sv
`timescale 1ns/1ps

module cnu_wr_update_handshake (
	output logic cnu_wr_o,
	output logic init_load_o,
	output logic pipe_load_o,

	input  logic iter_update_i,      // non-final iteration written back
	input  logic cnu_rd_finish_i,    // loader has a full frame buffered
	input  logic cnu_init_load_en_i, // sequencer sits in init load phase
	input  logic read_clk,
	input  logic rstn
);

	logic       init_req;
	logic       pipe_req;
	logic       load_any;
	logic [1:0] wr_pipe;  // load to write delay line, matches lane latency
	logic [1:0] wr_hist;  // last two samples of cnu_wr_o
	logic       wr_end;

	// requests only count on the cycle they are raised
	assign init_req = cnu_rd_finish_i & cnu_init_load_en_i & ~init_load_o;
	assign pipe_req = iter_update_i & ~pipe_load_o;

	assign load_any = init_load_o | pipe_load_o;

	// write seen two cycles back and gone one cycle back
	assign wr_end = (wr_hist == 2'b10);

	// load strobes, one cycle after their request
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			init_load_o <= 1'b0;
			pipe_load_o <= 1'b0;
		end else if (wr_end) begin
			// a finished write drops whatever strobe is still around
			init_load_o <= 1'b0;
			pipe_load_o <= 1'b0;
		end else begin
			init_load_o <= init_req;
			pipe_load_o <= pipe_req;
		end
	end

	// two stage delay, one write per load
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			wr_pipe <= 2'b00;
		end else begin
			wr_pipe <= {wr_pipe[0], load_any};
		end
	end

	assign cnu_wr_o = wr_pipe[1]; // lines up with lane res_valid

	// write history for the cancel above
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			wr_hist <= 2'b00;
		end else begin
			wr_hist <= {wr_hist[0], cnu_wr_o};
		end
	end

endmodule

// File: logic/cnu_iter_fsm.sv
`timescale 1ns/1ps

module cnu_iter_fsm (
	input  logic read_clk,
	input  logic rstn,
	input  logic rd_finish_i,       // frame ready in loader buffers
	input  logic cnu_wr_i,          // lane results valid
	input  logic collector_empty_i, // collector can take a frame
	output logic init_load_en_o,
	output logic iter_update_o,
	output logic frame_done_o
);

	cnu_pkg::cnu_phase_e             state;
	logic [cnu_pkg::ITER_W-1:0]      iter_cnt; // writes seen this frame
	logic                            wr_seen;  // final write arrived, collector busy

	assign init_load_en_o = (state == cnu_pkg::PHASE_INIT_LOAD);

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state         <= cnu_pkg::PHASE_IDLE;
			iter_cnt      <= '0;
			wr_seen       <= 1'b0;
			iter_update_o <= 1'b0;
			frame_done_o  <= 1'b0;
		end else begin
			iter_update_o <= 1'b0; // both are single pulses
			frame_done_o  <= 1'b0;
			case (state)
				cnu_pkg::PHASE_IDLE: begin
					state <= cnu_pkg::PHASE_INIT_LOAD; // arm for next frame
				end
				cnu_pkg::PHASE_INIT_LOAD: begin
					if (rd_finish_i) begin
						iter_cnt <= '0;
						wr_seen  <= 1'b0;
						// single iteration goes straight to the last write
						state    <= (cnu_pkg::ITER_NUM > 1) ? cnu_pkg::PHASE_PIPE_LOAD
						                                    : cnu_pkg::PHASE_WAIT_WR;
					end
				end
				cnu_pkg::PHASE_PIPE_LOAD: begin
					if (cnu_wr_i) begin
						iter_update_o <= 1'b1; // start the next pipe load
						iter_cnt      <= iter_cnt + 1'b1;
						// last pipe load now in flight
						if (iter_cnt == cnu_pkg::ITER_W'(cnu_pkg::ITER_NUM - 2))
							state <= cnu_pkg::PHASE_WAIT_WR;
					end
				end
				cnu_pkg::PHASE_WAIT_WR: begin
					if (cnu_wr_i || wr_seen) begin
						wr_seen <= 1'b1;
						if (collector_empty_i) begin
							frame_done_o <= 1'b1;
							wr_seen      <= 1'b0;
							state        <= cnu_pkg::PHASE_IDLE;
						end
					end
				end
				default: state <= cnu_pkg::PHASE_IDLE;
			endcase
		end
	end

endmodule

// File: logic/cnu_msg_loader.sv
`timescale 1ns/1ps

module cnu_msg_loader (
	input  logic              read_clk,
	input  logic              rstn,
	input  logic              in_valid_i,
	input  cnu_pkg::cnu_row_t in_row_i,
	input  logic              lane_free_i,  // collector emitted one lane
	output logic              in_credit_o,
	output logic              rd_finish_o,
	output cnu_pkg::cnu_row_t lane_row_o [cnu_pkg::NUM_CNU]
);

	logic [cnu_pkg::LANE_W-1:0] beat_cnt;  // next lane to fill
	logic                       last_beat;

	assign last_beat = in_valid_i && (beat_cnt == cnu_pkg::LANE_W'(cnu_pkg::NUM_CNU - 1));

	// beat counter and end of frame pulse
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			beat_cnt    <= '0;
			rd_finish_o <= 1'b0;
		end else begin
			rd_finish_o <= last_beat; // high the cycle after beat 3
			if (in_valid_i) begin
				if (last_beat)
					beat_cnt <= '0;
				else
					beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// lane buffers, filled in order
	always_ff @(posedge read_clk) begin
		if (in_valid_i)
			lane_row_o[beat_cnt] <= in_row_i;
	end

	// every freed buffer hands one credit back upstream
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			in_credit_o <= 1'b0;
		end else begin
			in_credit_o <= lane_free_i;
		end
	end

endmodule

// File: cnu/cnu_minsum.sv
`timescale 1ns/1ps

module cnu_minsum (
	input  logic              read_clk,
	input  logic              rstn,
	input  logic              init_load_i,  // take the loader row
	input  logic              pipe_load_i,  // take own previous result
	input  cnu_pkg::cnu_row_t load_row_i,
	output cnu_pkg::cnu_row_t res_row_o,
	output logic              res_valid_o
);

	cnu_pkg::cnu_row_t               src_row;
	logic                            load;
	logic [cnu_pkg::MAG_W-1:0]       min1;
	logic [cnu_pkg::MAG_W-1:0]       min2;
	logic [cnu_pkg::IDX_W-1:0]       min1_idx;
	logic                            parity;

	// stage 1 registers
	logic                            s1_valid;
	logic [cnu_pkg::MAG_W-1:0]       s1_min1;
	logic [cnu_pkg::MAG_W-1:0]       s1_min2;
	logic [cnu_pkg::IDX_W-1:0]       s1_idx;
	logic                            s1_par;
	logic [cnu_pkg::DC-1:0]          s1_sign;
	cnu_pkg::cnu_row_t               s2_row;

	assign load    = init_load_i | pipe_load_i;
	assign src_row = init_load_i ? load_row_i : res_row_o; // feedback on pipe load

	// two smallest magnitudes, where the smallest sits, sign parity
	always_comb begin
		min1     = '1;
		min2     = '1;
		min1_idx = '0;
		parity   = 1'b0;
		for (int i = 0; i < cnu_pkg::DC; i++) begin
			parity = parity ^ src_row.msg[i].sign;
			if (src_row.msg[i].mag < min1) begin
				min2     = min1;
				min1     = src_row.msg[i].mag;
				min1_idx = cnu_pkg::IDX_W'(i);
			end else if (src_row.msg[i].mag < min2) begin
				min2 = src_row.msg[i].mag;
			end
		end
	end

	// extrinsic message per edge, own contribution left out
	always_comb begin
		logic [cnu_pkg::MAG_W-1:0] m;
		for (int i = 0; i < cnu_pkg::DC; i++) begin
			m = (s1_idx == cnu_pkg::IDX_W'(i)) ? s1_min2 : s1_min1;
			s2_row.msg[i].sign = s1_par ^ s1_sign[i];
			s2_row.msg[i].mag  = (m > cnu_pkg::MAG_W'(cnu_pkg::OFFSET)) ?
			                     m - cnu_pkg::MAG_W'(cnu_pkg::OFFSET) : '0; // clamp at 0
		end
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			s1_valid    <= 1'b0;
			res_valid_o <= 1'b0;
		end else begin
			s1_valid    <= load;
			res_valid_o <= s1_valid; // two cycles after the load
		end
	end

	// payload, moves only with its valid
	always_ff @(posedge read_clk) begin
		if (load) begin
			s1_min1 <= min1;
			s1_min2 <= min2;
			s1_idx  <= min1_idx;
			s1_par  <= parity;
			for (int i = 0; i < cnu_pkg::DC; i++)
				s1_sign[i] <= src_row.msg[i].sign;
		end
		if (s1_valid)
			res_row_o <= s2_row; // held for the next pipe load
	end

endmodule

// File: logic/cnu_wr_collector.sv
`timescale 1ns/1ps

module cnu_wr_collector (
	input  logic              read_clk,
	input  logic              rstn,
	input  logic              frame_done_i,
	input  cnu_pkg::cnu_row_t lane_res_i [cnu_pkg::NUM_CNU],
	input  logic              out_credit_i, // one credit back per pulse
	output logic              out_valid_o,
	output cnu_pkg::cnu_out_t out_o,
	output logic              empty_o,
	output logic              lane_free_o
);

	cnu_pkg::cnu_row_t          hold_q [cnu_pkg::NUM_CNU];
	logic                       full_q;
	logic [cnu_pkg::LANE_W-1:0] idx_q;   // lane being drained
	logic [cnu_pkg::CRED_W-1:0] cred_q;
	logic                       capture;
	logic                       send;

	assign capture = frame_done_i && !full_q;
	assign send    = full_q && (cred_q != '0); // one beat spends one credit

	assign out_valid_o = send;
	assign out_o       = '{row: hold_q[idx_q], lane: idx_q};
	assign empty_o     = ~full_q;
	assign lane_free_o = send; // buffer slot free once its beat leaves

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			full_q <= 1'b0;
			idx_q  <= '0;
			cred_q <= cnu_pkg::CRED_W'(cnu_pkg::OUT_CREDITS);
		end else begin
			cred_q <= cred_q - cnu_pkg::CRED_W'(send) + cnu_pkg::CRED_W'(out_credit_i);
			if (capture) begin
				full_q <= 1'b1;
				idx_q  <= '0;
			end else if (send) begin
				idx_q <= idx_q + 1'b1;
				if (idx_q == cnu_pkg::LANE_W'(cnu_pkg::NUM_CNU - 1))
					full_q <= 1'b0; // last lane out
			end
		end
	end

	// holding register, all lanes at once
	always_ff @(posedge read_clk) begin
		if (capture)
			hold_q <= lane_res_i;
	end

endmodule

// File: logic/ldpc_cnu_top.sv
`timescale 1ns/1ps

module ldpc_cnu_top (
	input  logic              read_clk,
	input  logic              rstn,
	input  logic              in_valid_i,
	input  cnu_pkg::cnu_row_t in_row_i,
	input  logic              out_credit_i,
	output logic              in_credit_o,
	output logic              out_valid_o,
	output cnu_pkg::cnu_out_t out_o
);

	cnu_pkg::cnu_row_t            lane_row [cnu_pkg::NUM_CNU]; // loader buffers
	cnu_pkg::cnu_row_t            lane_res [cnu_pkg::NUM_CNU]; // lane results
	logic [cnu_pkg::NUM_CNU-1:0]  lane_valid;
	logic                         rd_finish;
	logic                         init_load_en;
	logic                         iter_update;
	logic                         init_load;
	logic                         pipe_load;
	logic                         cnu_wr;
	logic                         frame_done;
	logic                         coll_empty;
	logic                         lane_free;

	cnu_msg_loader u_loader (
		.read_clk    (read_clk),
		.rstn        (rstn),
		.in_valid_i  (in_valid_i),
		.in_row_i    (in_row_i),
		.lane_free_i (lane_free),
		.in_credit_o (in_credit_o),
		.rd_finish_o (rd_finish),
		.lane_row_o  (lane_row)
	);

	// one check node unit per lane
	for (genvar g = 0; g < cnu_pkg::NUM_CNU; g++) begin : g_lane
		cnu_minsum u_cnu (
			.read_clk    (read_clk),
			.rstn        (rstn),
			.init_load_i (init_load),
			.pipe_load_i (pipe_load),
			.load_row_i  (lane_row[g]),
			.res_row_o   (lane_res[g]),
			.res_valid_o (lane_valid[g])
		);
	end

	cnu_wr_update_handshake u_handshake (
		.cnu_wr_o           (cnu_wr),
		.init_load_o        (init_load),
		.pipe_load_o        (pipe_load),
		.iter_update_i      (iter_update),
		.cnu_rd_finish_i    (rd_finish),
		.cnu_init_load_en_i (init_load_en),
		.read_clk           (read_clk),
		.rstn               (rstn)
	);

	cnu_iter_fsm u_fsm (
		.read_clk          (read_clk),
		.rstn              (rstn),
		.rd_finish_i       (rd_finish),
		.cnu_wr_i          (cnu_wr),
		.collector_empty_i (coll_empty),
		.init_load_en_o    (init_load_en),
		.iter_update_o     (iter_update),
		.frame_done_o      (frame_done)
	);

	cnu_wr_collector u_collector (
		.read_clk     (read_clk),
		.rstn         (rstn),
		.frame_done_i (frame_done),
		.lane_res_i   (lane_res),
		.out_credit_i (out_credit_i),
		.out_valid_o  (out_valid_o),
		.out_o        (out_o),
		.empty_o      (coll_empty),
		.lane_free_o  (lane_free)
	);

endmodule

// File: test/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

endmodule

// File: test/ldpc_cnu_top_chk.sv
`timescale 1ns/1ps

module ldpc_cnu_top_chk (
	input logic read_clk,
	input logic rstn,
	input logic out_valid_i,
	input logic out_credit_i,
	input logic init_load_i,
	input logic pipe_load_i,
	input logic cnu_wr_i,
	input logic [cnu_pkg::NUM_CNU-1:0] lane_valid_i  // res_valid of every lane
);

	int fail_cnt = 0;  // failed assertions so far
	int cred_cnt;      // output credits as seen on the ports

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			cred_cnt <= cnu_pkg::OUT_CREDITS;
		else
			cred_cnt <= cred_cnt - int'(out_valid_i) + int'(out_credit_i);
	end

	// a beat needs a credit
	assert property (@(posedge read_clk) disable iff (!rstn) out_valid_i |-> cred_cnt > 0)
		else begin
			fail_cnt++;
			$error("out_valid_o raised with no output credit left");
		end

	// write lines up with lane latency, every lane done together
	assert property (@(posedge read_clk) disable iff (!rstn)
			(init_load_i || pipe_load_i) |-> ##2 (cnu_wr_i && (&lane_valid_i)))
		else begin
			fail_cnt++;
			$error("cnu_wr or lane res_valid missing two cycles after a load strobe");
		end

	assert property (@(posedge read_clk) !rstn |-> !(init_load_i || pipe_load_i))
		else begin
			fail_cnt++;
			$error("load strobe seen while in reset");
		end

endmodule

bind ldpc_cnu_top ldpc_cnu_top_chk u_chk (
	.read_clk     (read_clk),
	.rstn         (rstn),
	.out_valid_i  (out_valid_o),
	.out_credit_i (out_credit_i),
	.init_load_i  (init_load),
	.pipe_load_i  (pipe_load),
	.cnu_wr_i     (cnu_wr),
	.lane_valid_i (lane_valid)
);

// File: test/tb_ldpc_cnu_top.sv
`timescale 1ns/1ps

module tb_ldpc_cnu_top;

	localparam int NUM_FRAMES = 2;
	localparam int FRAME_ROWS = 2 * cnu_pkg::NUM_CNU;        // inputs, then expected rows
	localparam int NUM_BEATS  = NUM_FRAMES * cnu_pkg::NUM_CNU;
	localparam int RUN_LIMIT  = 2000;                        // cycles
	localparam int HOLD_LEN   = 20;                          // credits withheld this long

	logic              read_clk;
	logic              rstn;
	logic              in_valid_i;
	cnu_pkg::cnu_row_t in_row_i;
	logic              out_credit_i;
	logic              in_credit_o;
	logic              out_valid_o;
	cnu_pkg::cnu_out_t out_o;

	logic [cnu_pkg::DC*cnu_pkg::MSG_W-1:0] trace_mem [NUM_FRAMES*FRAME_ROWS];
	integer seed = 53225;
	int     err_cnt = 0;
	int     in_cred = cnu_pkg::IN_CREDITS;  // upstream credit model
	int     owed = 0;                       // beats not yet credited back
	int     sent = 0;
	int     rcvd = 0;
	int     cred_pulses = 0;
	int     gap = 0;
	int     hold = HOLD_LEN;
	int     cyc;

	tb_clkgen u_clk (.clk_o(read_clk));

	ldpc_cnu_top uut (
		.read_clk     (read_clk),
		.rstn         (rstn),
		.in_valid_i   (in_valid_i),
		.in_row_i     (in_row_i),
		.out_credit_i (out_credit_i),
		.in_credit_o  (in_credit_o),
		.out_valid_o  (out_valid_o),
		.out_o        (out_o)
	);

	task automatic check_outputs();
		int f;
		int l;
		cnu_pkg::cnu_row_t exp_row;
		f = rcvd / cnu_pkg::NUM_CNU;
		l = rcvd % cnu_pkg::NUM_CNU;
		if (in_credit_o) begin
			cred_pulses++;
			in_cred++;
		end
		assert (in_cred <= cnu_pkg::IN_CREDITS) else begin
			err_cnt++;
			$display("in_credit_o gave back more credits than were spent");
		end
		if (out_valid_o) begin
			owed++;
			assert (owed <= cnu_pkg::OUT_CREDITS) else begin
				err_cnt++;
				$display("more output beats than output credits");
			end
			assert (rcvd < NUM_BEATS) else begin
				err_cnt++;
				$display("output beat beyond the last expected frame");
			end
			if (rcvd < NUM_BEATS) begin
				exp_row = trace_mem[f*FRAME_ROWS + cnu_pkg::NUM_CNU + l];
				assert (out_o.row == exp_row) else begin
					err_cnt++;
					$display("ERROR: out_o.row frame %0d got %h expected %h",
					         f, out_o.row, exp_row);
				end
				assert (out_o.lane == l) else begin
					err_cnt++;
					$display("ERROR: out_o.lane got %h expected %h", out_o.lane, l);
				end
			end
			rcvd++;
		end
	endtask

	// next beat whenever a credit is held
	task automatic drive_stimulus();
		in_valid_i = 1'b0;
		if (in_cred > 0 && sent < NUM_BEATS) begin
			in_valid_i = 1'b1;
			in_row_i   = trace_mem[(sent / cnu_pkg::NUM_CNU)*FRAME_ROWS + sent % cnu_pkg::NUM_CNU];
			in_cred--;
			sent++;
		end
	endtask

	task automatic return_credit();
		out_credit_i = 1'b0;
		if (hold > 0) begin
			if (owed == cnu_pkg::OUT_CREDITS)
				hold--;  // pool drained, keep it dry a while
		end else if (owed > 0) begin
			if (gap == 0) begin
				out_credit_i = 1'b1;
				owed--;
				gap = $unsigned($random(seed)) % 4;  // random spacing
			end else begin
				gap--;
			end
		end
	endtask

	initial begin
		in_valid_i   = 1'b0;
		in_row_i     = '0;
		out_credit_i = 1'b0;
		rstn         = 1'b0;
		$readmemh("test/cnu_trace.txt", trace_mem);
		repeat (16) @(posedge read_clk);
		#1 rstn = 1'b1;
		// quiet outputs before any beat
		for (cyc = 0; cyc < 8; cyc++) begin
			@(posedge read_clk);
			#1;
			assert (!in_credit_o && !out_valid_o) else begin
				err_cnt++;
				$display("ERROR: in_credit_o %h out_valid_o %h expected 0", in_credit_o, out_valid_o);
			end
		end
		cyc = 0;
		while (rcvd < NUM_BEATS && cyc < RUN_LIMIT) begin
			@(posedge read_clk);
			#1;
			check_outputs();
			drive_stimulus();
			return_credit();
			cyc++;
		end
		in_valid_i   = 1'b0;
		out_credit_i = 1'b0;
		if (rcvd < NUM_BEATS) begin
			err_cnt++;
			$display("timed out with %0d of %0d output beats received", rcvd, NUM_BEATS);
		end
		cyc = 0;
		while (cred_pulses < NUM_BEATS && cyc < 10) begin  // last credit trails the beat
			@(posedge read_clk);
			#1;
			check_outputs();
			cyc++;
		end
		assert (cred_pulses == NUM_BEATS) else begin
			err_cnt++;
			$display("ERROR: in_credit_o pulses %h expected %h", cred_pulses, NUM_BEATS);
		end
		$display("errors: checks %0d, assertions %0d", err_cnt, uut.u_chk.fail_cnt);
		if (err_cnt == 0 && uut.u_chk.fail_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: sources.f
common/cnu_pkg.sv
logic/cnu_wr_update_handshake.sv
logic/cnu_iter_fsm.sv
logic/cnu_msg_loader.sv
cnu/cnu_minsum.sv
logic/cnu_wr_collector.sv
logic/ldpc_cnu_top.sv
test/tb_clkgen.sv
test/ldpc_cnu_top_chk.sv
test/tb_ldpc_cnu_top.sv

// File: test/cnu_trace.txt
// one 16 bit hex row per line, nibbles msg3 msg2 msg1 msg0, each nibble sign then 3 bit magnitude
// per frame 4 input rows for lanes 0..3, then the 4 expected output rows after 3 iterations
// frame 0
77E7
6F37
7FFF
E7D0
BB3B
8088
C444
8080
// frame 1
7777
FFFF
7F72
7D67
4444
CCCC
8088
A2AA
